// File: common/wsg_pkg.sv
`default_nettype none

package wsg_pkg;

	//////////////////////////////
	// voice and memory sizes
	//////////////////////////////
	localparam int NUM_VOICES  = 8;  // voices mixed per frame
	localparam int VOICE_W     = 3;  // voice index
	localparam int PTR_W       = 6;  // byte pointer into a 64 byte waveform
	localparam int ACC_W       = 22; // phase accumulator
	localparam int FREQ_W      = 16; // frequency word
	localparam int MIX_W       = 24; // mix accumulator, one guard bit above the sample
	localparam int SMP_W       = 16; // output sample, top of the mix
	localparam int WAVE_ADDR_W = 7;  // wave ram word address, {voice, ptr[5:2]}

	//////////////////////////////
	// enums
	//////////////////////////////
	// bus address regions
	typedef enum logic [1:0] {
		region_wave,    // addr[7] low
		region_voice,   // addr[7:3] == 11101
		region_pointer, // addr[7:3] == 11111, read only
		region_none     // everything else reads zero
	} bus_region_e;

	// frame sequencer states
	typedef enum logic [1:0] {
		st_phase,     // kick the phase engine and wait for it
		st_mix_left,  // left pass over 8 voices x 2 nybbles
		st_mix_right, // right pass
		st_hold       // sample offered, waiting for ready
	} mix_state_e;

endpackage

`default_nettype wire

// File: voice_regs/voice_regs.sv
`timescale 1ns/1ns
`default_nettype none

module voice_regs (
	input  wire logic                                           i_Clk,
	input  wire logic                                           i_arst_n,
	input  wire logic                                           i_bus_write,
	input  wire logic                                           i_bus_read,
	input  wire logic [7:0]                                     i_bus_addr,
	input  wire logic [3:0]                                     i_bus_byte_en,
	input  wire logic [31:0]                                    i_bus_wdata,
	input  wire logic [wsg_pkg::WAVE_ADDR_W-1:0]                i_wave_rd_addr,
	input  wire logic [wsg_pkg::NUM_VOICES*wsg_pkg::PTR_W-1:0]  i_pointers,
	output logic      [31:0]                                    o_bus_rdata,
	output logic      [31:0]                                    o_wave_rd_data,
	output logic      [wsg_pkg::NUM_VOICES*wsg_pkg::FREQ_W-1:0] o_freq,
	output logic      [wsg_pkg::NUM_VOICES*8-1:0]               o_vol_left,
	output logic      [wsg_pkg::NUM_VOICES*8-1:0]               o_vol_right
);

	localparam int NV = wsg_pkg::NUM_VOICES;

	wsg_pkg::bus_region_e region;
	logic [wsg_pkg::WAVE_ADDR_W-1:0] wave_addr; // bus side wave word
	logic [wsg_pkg::VOICE_W-1:0] voice_sel;     // voice for register and pointer regions

	// lane 3 is bits 31..24 and holds pointer byte 0 of the word
	logic [3:0][7:0] wave_mem [2**wsg_pkg::WAVE_ADDR_W];

	logic [7:0] freq_lo [NV];
	logic [7:0] freq_hi [NV];
	logic [7:0] vol_left [NV];  // {nybble 0, nybble 1}
	logic [7:0] vol_right [NV];

	assign wave_addr = i_bus_addr[wsg_pkg::WAVE_ADDR_W-1:0];
	assign voice_sel = i_bus_addr[wsg_pkg::VOICE_W-1:0];

	//////////////////////////////
	// address decode
	//////////////////////////////
	always_comb begin
		if (!i_bus_addr[7]) begin
			region = wsg_pkg::region_wave;
		end else if (i_bus_addr[7:3] == 5'b11101) begin
			region = wsg_pkg::region_voice;
		end else if (i_bus_addr[7:3] == 5'b11111) begin
			region = wsg_pkg::region_pointer;
		end else begin
			region = wsg_pkg::region_none; // reads as zero, writes dropped
		end
	end

	//////////////////////////////
	// wave ram, bus write port plus mixer read port
	//////////////////////////////
	always_ff @(posedge i_Clk) begin
		if (i_bus_write && region == wsg_pkg::region_wave) begin
			for (int b = 0; b < 4; b++) begin
				if (i_bus_byte_en[b]) begin
					wave_mem[wave_addr][b] <= i_bus_wdata[8*b +: 8];
				end
			end
		end
		o_wave_rd_data <= wave_mem[i_wave_rd_addr]; // one cycle behind the mixer address
	end

	// voice registers, all voices start silent at frequency zero
	always_ff @(posedge i_Clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int v = 0; v < NV; v++) begin
				freq_lo[v]   <= '0;
				freq_hi[v]   <= '0;
				vol_left[v]  <= '0;
				vol_right[v] <= '0;
			end
		end else if (i_bus_write && region == wsg_pkg::region_voice) begin
			if (i_bus_byte_en[3]) freq_lo[voice_sel]   <= i_bus_wdata[31:24];
			if (i_bus_byte_en[2]) freq_hi[voice_sel]   <= i_bus_wdata[23:16];
			if (i_bus_byte_en[1]) vol_left[voice_sel]  <= i_bus_wdata[15:8];
			if (i_bus_byte_en[0]) vol_right[voice_sel] <= i_bus_wdata[7:0];
		end
	end

	//////////////////////////////
	// bus read data, held until next read
	//////////////////////////////
	always_ff @(posedge i_Clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_bus_rdata <= '0;
		end else if (i_bus_read) begin
			case (region)
				wsg_pkg::region_wave:    o_bus_rdata <= wave_mem[wave_addr];
				wsg_pkg::region_voice:   o_bus_rdata <= {freq_lo[voice_sel], freq_hi[voice_sel],
				                                         vol_left[voice_sel], vol_right[voice_sel]};
				wsg_pkg::region_pointer: o_bus_rdata <= {{(8-wsg_pkg::PTR_W){1'b0}},
				                                         i_pointers[voice_sel*wsg_pkg::PTR_W +:
				                                                    wsg_pkg::PTR_W],
				                                         24'h000000}; // pointer in 29..24
				default:                 o_bus_rdata <= '0;
			endcase
		end
	end

	// flatten the arrays for the phase engine and mixer
	for (genvar gv = 0; gv < NV; gv++) begin : g_flat
		assign o_freq[gv*wsg_pkg::FREQ_W +: wsg_pkg::FREQ_W] = {freq_hi[gv], freq_lo[gv]};
		assign o_vol_left[gv*8 +: 8]  = vol_left[gv];
		assign o_vol_right[gv*8 +: 8] = vol_right[gv];
	end

endmodule

`default_nettype wire

// File: verilog/phase_engine.sv
`timescale 1ns/1ns
`default_nettype none

module phase_engine #(
	parameter int p_freq_shift = 5 // frequency word scaling into the accumulator
) (
	input  wire logic                                           i_Clk,
	input  wire logic                                           i_arst_n,
	input  wire logic                                           i_frame_start,
	input  wire logic [wsg_pkg::NUM_VOICES*wsg_pkg::FREQ_W-1:0] i_freq,
	output logic                                                o_phase_done,
	output logic      [wsg_pkg::NUM_VOICES*wsg_pkg::PTR_W-1:0]  o_pointers
);

	localparam int NV    = wsg_pkg::NUM_VOICES;
	localparam int ACC_W = wsg_pkg::ACC_W;
	localparam int PTR_W = wsg_pkg::PTR_W;

	logic [ACC_W-1:0] acc [NV];
	logic [PTR_W-1:0] ptr [NV];
	logic [ACC_W-1:0] acc_hold;           // summed accumulator between the two voice cycles
	logic [wsg_pkg::VOICE_W:0] step;      // {voice, second cycle}
	logic busy;
	logic active;
	logic [wsg_pkg::VOICE_W-1:0] voice;
	logic [wsg_pkg::FREQ_W-1:0] freq_v;
	logic [ACC_W-1:0] freq_inc;

	// the start pulse itself runs step 0, so done lands 16 cycles after it
	assign active   = i_frame_start | busy;
	assign voice    = step[wsg_pkg::VOICE_W:1];
	assign freq_v   = i_freq[voice*wsg_pkg::FREQ_W +: wsg_pkg::FREQ_W];
	assign freq_inc = {{(ACC_W-wsg_pkg::FREQ_W){1'b0}}, freq_v} << p_freq_shift;

	always_ff @(posedge i_Clk) begin
		if (active && !step[0]) begin
			acc_hold <= acc[voice] + freq_inc; // first cycle of a voice
		end
	end

	//////////////////////////////
	// per voice frame rule
	//////////////////////////////
	always_ff @(posedge i_Clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			step         <= '0;
			busy         <= 1'b0;
			o_phase_done <= 1'b0;
			for (int v = 0; v < NV; v++) begin
				acc[v] <= '0;
				ptr[v] <= '0;
			end
		end else begin
			o_phase_done <= active && (&step); // last voice done this cycle
			if (active) begin
				step <= step + 1'b1;  // wraps back to 0 after voice 7
				busy <= !(&step);
				if (step[0]) begin
					// whole wraps of bits 21..16 move the pointer, possibly several bytes
					ptr[voice] <= ptr[voice] + acc_hold[ACC_W-1 -: PTR_W];
					acc[voice] <= {{PTR_W{1'b0}}, acc_hold[ACC_W-PTR_W-1:0]};
				end
			end
		end
	end

	for (genvar gv = 0; gv < NV; gv++) begin : g_ptr_flat
		assign o_pointers[gv*PTR_W +: PTR_W] = ptr[gv];
	end

endmodule

`default_nettype wire

// File: mixer/stereo_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module stereo_mixer (
	input  wire logic                                          i_Clk,
	input  wire logic                                          i_arst_n,
	input  wire logic                                          i_phase_done,
	input  wire logic [wsg_pkg::NUM_VOICES*wsg_pkg::PTR_W-1:0] i_pointers,
	input  wire logic [wsg_pkg::NUM_VOICES*8-1:0]              i_vol_left,
	input  wire logic [wsg_pkg::NUM_VOICES*8-1:0]              i_vol_right,
	input  wire logic [31:0]                                   i_wave_rd_data,
	input  wire logic                                          i_smp_ready,
	output logic                                               o_frame_start,
	output logic      [wsg_pkg::WAVE_ADDR_W-1:0]               o_wave_rd_addr,
	output logic signed [wsg_pkg::SMP_W-1:0]                   o_smp_left,
	output logic signed [wsg_pkg::SMP_W-1:0]                   o_smp_right,
	output logic                                               o_smp_valid
);

	localparam int PTR_W    = wsg_pkg::PTR_W;
	localparam int MIX_W    = wsg_pkg::MIX_W;
	localparam int STEP_W   = wsg_pkg::VOICE_W + 2; // 0..15 issue, 16 drains the pipe
	localparam int WAVE_POS = 15;                   // sample sits 15 bits up before the shift

	wsg_pkg::mix_state_e state;
	logic [STEP_W-1:0] step;
	logic phase_wait;                     // start issued, waiting for phase done
	logic in_mix;
	logic issuing;
	logic [wsg_pkg::VOICE_W-1:0] voice;
	logic [PTR_W-1:0] ptr;
	logic [7:0] vol;                      // this channel's two nybbles

	// stage 1 to stage 2
	logic s1_valid;
	logic s1_mute;
	logic [3:0] s1_nyb;
	logic [1:0] s1_lane;

	logic [7:0] wave_byte;
	logic signed [MIX_W-1:0] term;
	logic signed [MIX_W-1:0] mix;
	logic signed [wsg_pkg::SMP_W-1:0] left_q;

	assign in_mix  = (state == wsg_pkg::st_mix_left) || (state == wsg_pkg::st_mix_right);
	assign issuing = in_mix && !step[STEP_W-1];
	assign voice   = step[wsg_pkg::VOICE_W:1]; // step[0] picks the nybble
	assign ptr     = i_pointers[voice*PTR_W +: PTR_W];
	assign vol     = (state == wsg_pkg::st_mix_right) ? i_vol_right[voice*8 +: 8]
	                                                  : i_vol_left[voice*8 +: 8];
	assign o_wave_rd_addr = {voice, ptr[PTR_W-1:2]};

	//////////////////////////////
	// frame sequencer
	//////////////////////////////
	always_ff @(posedge i_Clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state         <= wsg_pkg::st_phase;
			step          <= '0;
			phase_wait    <= 1'b0;
			o_frame_start <= 1'b0;
			o_smp_valid   <= 1'b0;
		end else begin
			o_frame_start <= 1'b0; // single cycle pulse
			case (state)
				wsg_pkg::st_phase: begin
					if (!phase_wait) begin
						o_frame_start <= 1'b1;
						phase_wait    <= 1'b1;
					end else if (i_phase_done) begin
						phase_wait <= 1'b0;
						state      <= wsg_pkg::st_mix_left;
					end
				end
				wsg_pkg::st_mix_left: begin
					if (step[STEP_W-1]) begin
						step  <= '0;
						state <= wsg_pkg::st_mix_right;
					end else begin
						step <= step + 1'b1;
					end
				end
				wsg_pkg::st_mix_right: begin
					if (step[STEP_W-1]) begin
						step        <= '0;
						o_smp_valid <= 1'b1; // last term lands on this same edge
						state       <= wsg_pkg::st_hold;
					end else begin
						step <= step + 1'b1;
					end
				end
				default: begin
					if (i_smp_ready) begin // frozen here until the sample is taken
						o_smp_valid <= 1'b0;
						state       <= wsg_pkg::st_phase;
					end
				end
			endcase
		end
	end

	// stage 1, address goes out combinationally, flags wait for the ram word
	always_ff @(posedge i_Clk) begin
		s1_nyb  <= step[0] ? vol[3:0] : vol[7:4];
		s1_mute <= (vol == 8'h00); // both nybbles zero
		s1_lane <= ptr[1:0];
		if (state == wsg_pkg::st_mix_right && step == '0) begin
			left_q <= mix[MIX_W-1 -: wsg_pkg::SMP_W]; // left pass total, before the clear
		end
	end

	// stage 2 byte select and volume shift
	always_comb begin
		case (s1_lane)
			2'd0:    wave_byte = i_wave_rd_data[31:24];
			2'd1:    wave_byte = i_wave_rd_data[23:16];
			2'd2:    wave_byte = i_wave_rd_data[15:8];
			default: wave_byte = i_wave_rd_data[7:0];
		endcase
		term = $signed({{(MIX_W-8-WAVE_POS){wave_byte[7]}}, wave_byte, {WAVE_POS{1'b0}}})
		       >>> (4'hF - s1_nyb); // nybble 15 is full scale
	end

	//////////////////////////////
	// accumulate
	//////////////////////////////
	always_ff @(posedge i_Clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			s1_valid <= 1'b0;
			mix      <= '0;
		end else begin
			s1_valid <= issuing;
			if (s1_valid && !s1_mute) begin
				mix <= mix + term;
			end else if (in_mix && step == '0) begin
				mix <= '0; // nothing in flight on step 0
			end
		end
	end

	// both stay put through st_hold
	assign o_smp_left  = left_q;
	assign o_smp_right = mix[MIX_W-1 -: wsg_pkg::SMP_W];

endmodule

`default_nettype wire

// File: verilog/wsg_top.sv
`timescale 1ns/1ns
`default_nettype none

module wsg_top #(
	parameter int p_freq_shift = 5 // accumulator scaling, transposes pitch only
) (
	input  wire logic                            i_Clk,
	input  wire logic                            i_arst_n,
	input  wire logic                            i_bus_write,
	input  wire logic                            i_bus_read,
	input  wire logic [7:0]                      i_bus_addr,
	input  wire logic [3:0]                      i_bus_byte_en,
	input  wire logic [31:0]                     i_bus_wdata,
	output logic      [31:0]                     o_bus_rdata,
	output logic signed [wsg_pkg::SMP_W-1:0]     o_smp_left,
	output logic signed [wsg_pkg::SMP_W-1:0]     o_smp_right,
	output logic                                 o_smp_valid,
	input  wire logic                            i_smp_ready
);

	//////////////////////////////
	// internal nets
	//////////////////////////////
	logic [wsg_pkg::WAVE_ADDR_W-1:0]                wave_rd_addr;
	logic [31:0]                                    wave_rd_data;
	logic [wsg_pkg::NUM_VOICES*wsg_pkg::FREQ_W-1:0] freq;
	logic [wsg_pkg::NUM_VOICES*8-1:0]               vol_left;
	logic [wsg_pkg::NUM_VOICES*8-1:0]               vol_right;
	logic [wsg_pkg::NUM_VOICES*wsg_pkg::PTR_W-1:0]  pointers;
	logic                                           frame_start;
	logic                                           phase_done;

	// bus side registers and wave ram
	voice_regs u_regs (
		.i_Clk          (i_Clk),
		.i_arst_n       (i_arst_n),
		.i_bus_write    (i_bus_write),
		.i_bus_read     (i_bus_read),
		.i_bus_addr     (i_bus_addr),
		.i_bus_byte_en  (i_bus_byte_en),
		.i_bus_wdata    (i_bus_wdata),
		.i_wave_rd_addr (wave_rd_addr),
		.i_pointers     (pointers),
		.o_bus_rdata    (o_bus_rdata),
		.o_wave_rd_data (wave_rd_data),
		.o_freq         (freq),
		.o_vol_left     (vol_left),
		.o_vol_right    (vol_right)
	);

	phase_engine #(
		.p_freq_shift (p_freq_shift)
	) u_phase (
		.i_Clk         (i_Clk),
		.i_arst_n      (i_arst_n),
		.i_frame_start (frame_start),
		.i_freq        (freq),
		.o_phase_done  (phase_done),
		.o_pointers    (pointers)
	);

	// sequencer and mix, paces frames from the output handshake
	stereo_mixer u_mixer (
		.i_Clk          (i_Clk),
		.i_arst_n       (i_arst_n),
		.i_phase_done   (phase_done),
		.i_pointers     (pointers),
		.i_vol_left     (vol_left),
		.i_vol_right    (vol_right),
		.i_wave_rd_data (wave_rd_data),
		.i_smp_ready    (i_smp_ready),
		.o_frame_start  (frame_start),
		.o_wave_rd_addr (wave_rd_addr),
		.o_smp_left     (o_smp_left),
		.o_smp_right    (o_smp_right),
		.o_smp_valid    (o_smp_valid)
	);

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
	parameter int p_period       = 20, // ns
	parameter int p_reset_cycles = 8
) (
	output logic o_Clk,
	output logic o_arst_n
);

	initial begin
		o_Clk = 1'b0;
		forever begin
			#(p_period / 2) o_Clk = ~o_Clk;
		end
	end

	// reset lifts on a falling edge, well clear of the rising ones
	initial begin
		o_arst_n = 1'b0;
		repeat (p_reset_cycles) @(posedge o_Clk);
		@(negedge o_Clk);
		o_arst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: tests/wsg_props.sv
`timescale 1ns/1ns
`default_nettype none

module wsg_props (
	input wire logic                     i_Clk,
	input wire logic                     i_arst_n,
	input wire logic                     i_frame_start,
	input wire logic                     i_phase_done,
	input wire logic                     i_smp_valid,
	input wire logic                     i_smp_ready,
	input wire logic [wsg_pkg::SMP_W-1:0] i_smp_left,
	input wire logic [wsg_pkg::SMP_W-1:0] i_smp_right
);

	//////////////////////////////
	// sample output handshake
	//////////////////////////////
	// an offered sample stays put until it is taken
	a_hold_stable: assert property (@(posedge i_Clk) disable iff (!i_arst_n)
		i_smp_valid && !i_smp_ready |=> i_smp_valid && $stable(i_smp_left) && $stable(i_smp_right))
		else $error("sample dropped or changed before ready");

	// no new frame while the old sample waits
	a_start_idle: assert property (@(posedge i_Clk) disable iff (!i_arst_n)
		i_frame_start |-> !i_smp_valid)
		else $error("frame start while a sample is offered");

	//////////////////////////////
	// phase engine timing
	//////////////////////////////
	a_done_after_start: assert property (@(posedge i_Clk) disable iff (!i_arst_n)
		i_frame_start |-> ##16 i_phase_done) // two cycles per voice
		else $error("phase done missing 16 cycles after frame start");

	a_done_needs_start: assert property (@(posedge i_Clk) disable iff (!i_arst_n)
		i_phase_done |-> $past(i_frame_start, 16))
		else $error("phase done without a frame start 16 cycles before");

endmodule

`default_nettype wire

// File: tests/wsg_tb.sv
`timescale 1ns/1ns
`default_nettype none

module wsg_tb;

	localparam int NV         = wsg_pkg::NUM_VOICES;
	localparam int FREQ_SHIFT = 5;
	localparam int TIMEOUT    = 200; // cycles, a frame takes about 55
	localparam int NUM_FRAMES = 40;

	logic        clk;
	logic        arst_n;
	logic        bus_write;
	logic        bus_read;
	logic [7:0]  bus_addr;
	logic [3:0]  bus_byte_en;
	logic [31:0] bus_wdata;
	logic [31:0] bus_rdata;
	logic signed [15:0] smp_left;
	logic signed [15:0] smp_right;
	logic        smp_valid;
	logic        smp_ready;

	// reference model state
	logic [31:0] m_wave [2**wsg_pkg::WAVE_ADDR_W];
	logic [15:0] m_freq [NV];
	logic [7:0]  m_vol_l [NV]; // {nybble 0, nybble 1}
	logic [7:0]  m_vol_r [NV];
	logic [21:0] m_acc [NV];
	logic [5:0]  m_ptr [NV];

	integer seed;
	int errors;
	int timeouts;
	int samples;

	tb_clk_gen #(.p_period(20), .p_reset_cycles(8)) u_clk (.o_Clk(clk), .o_arst_n(arst_n));

	wsg_top #(.p_freq_shift(FREQ_SHIFT)) dut (
		.i_Clk         (clk),
		.i_arst_n      (arst_n),
		.i_bus_write   (bus_write),
		.i_bus_read    (bus_read),
		.i_bus_addr    (bus_addr),
		.i_bus_byte_en (bus_byte_en),
		.i_bus_wdata   (bus_wdata),
		.o_bus_rdata   (bus_rdata),
		.o_smp_left    (smp_left),
		.o_smp_right   (smp_right),
		.o_smp_valid   (smp_valid),
		.i_smp_ready   (smp_ready)
	);

	bind wsg_top wsg_props u_props (
		.i_Clk         (i_Clk),
		.i_arst_n      (i_arst_n),
		.i_frame_start (frame_start),
		.i_phase_done  (phase_done),
		.i_smp_valid   (o_smp_valid),
		.i_smp_ready   (i_smp_ready),
		.i_smp_left    (o_smp_left),
		.i_smp_right   (o_smp_right)
	);

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	task automatic next_cycle(); // every drive and sample point is 2 ns past the edge
		@(posedge clk);
		#2;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		assert (expected == actual) else begin
			errors++;
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	//////////////////////////////
	// bus access and model mirror
	//////////////////////////////
	task automatic model_write(input logic [7:0] addr, input logic [3:0] be,
	                           input logic [31:0] data);
		logic [2:0] v;
		v = addr[2:0];
		if (!addr[7]) begin
			for (int b = 0; b < 4; b++) begin
				if (be[b]) m_wave[addr[6:0]][8*b +: 8] = data[8*b +: 8];
			end
		end else if (addr[7:3] == 5'b11101) begin
			if (be[3]) m_freq[v][7:0]  = data[31:24];
			if (be[2]) m_freq[v][15:8] = data[23:16];
			if (be[1]) m_vol_l[v]      = data[15:8];
			if (be[0]) m_vol_r[v]      = data[7:0];
		end // pointer and unmapped writes go nowhere
	endtask

	function automatic logic [31:0] model_read(input logic [7:0] addr);
		logic [2:0] v;
		v = addr[2:0];
		if (!addr[7]) begin
			return m_wave[addr[6:0]];
		end else if (addr[7:3] == 5'b11101) begin
			return {m_freq[v][7:0], m_freq[v][15:8], m_vol_l[v], m_vol_r[v]};
		end else if (addr[7:3] == 5'b11111) begin
			return {2'b00, m_ptr[v], 24'h000000};
		end
		return 32'h0;
	endfunction

	task automatic write_tracked(input logic [7:0] addr, input logic [3:0] be,
	                             input logic [31:0] data);
		bus_addr    = addr;
		bus_byte_en = be;
		bus_wdata   = data;
		bus_write   = 1'b1;
		next_cycle();
		bus_write = 1'b0;
		model_write(addr, be, data);
	endtask

	task automatic read_check(input logic [7:0] addr);
		bus_addr = addr;
		bus_read = 1'b1;
		next_cycle(); // registered, valid right after this edge
		bus_read = 1'b0;
		check_value($sformatf("o_bus_rdata[%02h]", addr), model_read(addr), bus_rdata);
	endtask

	task automatic random_bus_ops(input int count);
		logic [31:0] r;
		logic [7:0]  addr;
		repeat (count) begin
			r = next_rand();
			case (r[1:0])
				2'd0:    addr = {1'b0, r[8:2]};      // wave ram
				2'd1:    addr = {5'b11101, r[4:2]};  // voice register
				2'd2:    addr = {5'b11111, r[4:2]};  // pointer, read only
				default: addr = r[9] ? {3'b100, r[6:2]} : {5'b11110, r[4:2]};
			endcase
			if (r[10]) write_tracked(addr, r[14:11], next_rand());
			read_check(addr);
		end
	endtask

	task automatic fill_wave();
		for (int w = 0; w < 2**wsg_pkg::WAVE_ADDR_W; w++) begin
			write_tracked({1'b0, w[6:0]}, 4'hF, next_rand());
		end
	endtask

	// mute, one nybble only, or any byte
	function automatic logic [7:0] pick_volume(input logic [9:0] bits);
		case (bits[9:8])
			2'd0:    return 8'h00;
			2'd1:    return {4'h0, bits[3:0]};
			2'd2:    return {bits[7:4], 4'h0};
			default: return bits[7:0];
		endcase
	endfunction

	task automatic reconfigure_voices();
		logic [31:0] r;
		logic [31:0] s;
		logic [15:0] freq;
		for (int v = 0; v < NV; v++) begin
			r = next_rand();
			s = next_rand();
			freq = r[16] ? {5'b00000, r[10:0]} : r[15:0]; // slow, or several bytes per frame
			write_tracked({5'b11101, v[2:0]}, 4'hF,
			              {freq[7:0], freq[15:8], pick_volume(s[9:0]), pick_volume(s[19:10])});
		end
	endtask

	//////////////////////////////
	// frame and mix rules
	//////////////////////////////
	task automatic model_frame();
		for (int v = 0; v < NV; v++) begin
			m_acc[v] = m_acc[v] + ({6'b000000, m_freq[v]} << FREQ_SHIFT);
			m_ptr[v] = m_ptr[v] + m_acc[v][21:16];   // whole wraps, may skip bytes
			m_acc[v][21:16] = 6'b000000;
		end
	endtask

	function automatic logic [7:0] wave_at(input logic [2:0] voice, input logic [5:0] ptr);
		logic [31:0] word;
		word = m_wave[{voice, ptr[5:2]}];
		return word[8*(3 - ptr[1:0]) +: 8]; // pointer byte 0 in the top lane
	endfunction

	function automatic logic [15:0] mix_channel(input logic right);
		logic signed [23:0] mix;
		logic signed [23:0] term;
		logic [7:0] vol;
		logic [7:0] wave_byte;
		logic [3:0] nyb;
		mix = '0;
		for (int v = 0; v < NV; v++) begin
			vol       = right ? m_vol_r[v] : m_vol_l[v];
			wave_byte = wave_at(v[2:0], m_ptr[v]);
			if (vol != 8'h00) begin
				for (int k = 0; k < 2; k++) begin
					nyb  = (k == 0) ? vol[7:4] : vol[3:0];
					term = $signed({{16{wave_byte[7]}}, wave_byte}) <<< 15;
					term = term >>> (15 - nyb);
					mix  = mix + term; // wraps at 24 bits
				end
			end
		end
		return mix[23:8];
	endfunction

	//////////////////////////////
	// sample handshake
	//////////////////////////////
	task automatic wait_sample(output logic ok);
		int count;
		count = 0;
		while (!smp_valid && count < TIMEOUT) begin
			next_cycle();
			count++;
		end
		ok = smp_valid;
		if (!ok) begin
			timeouts++;
			$display("timeout: no sample offered within %0d cycles at t=%0t", TIMEOUT, $time);
		end
	endtask

	task automatic hold_stretch(input int cycles, input logic [15:0] exp_l,
	                            input logic [15:0] exp_r);
		repeat (cycles) begin
			next_cycle();
			check_value("o_smp_valid", 32'd1, {31'd0, smp_valid});
			check_value("o_smp_left", {16'h0000, exp_l}, {16'h0000, smp_left});
			check_value("o_smp_right", {16'h0000, exp_r}, {16'h0000, smp_right});
		end
	endtask

	task automatic accept_sample();
		smp_ready = 1'b1;
		next_cycle(); // transfer on this edge
		smp_ready = 1'b0;
	endtask

	initial begin
		logic        ok;
		logic        early;
		logic [31:0] r;
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		int          n;
		seed        = 32'h50d3;
		errors      = 0;
		timeouts    = 0;
		samples     = 0;
		bus_write   = 1'b0;
		bus_read    = 1'b0;
		bus_addr    = 8'h00;
		bus_byte_en = 4'h0;
		bus_wdata   = 32'h0;
		smp_ready   = 1'b0;
		for (int v = 0; v < NV; v++) begin
			m_freq[v]  = '0;
			m_vol_l[v] = '0;
			m_vol_r[v] = '0;
			m_acc[v]   = '0;
			m_ptr[v]   = '0;
		end

		n = 0;
		while (arst_n !== 1'b1 && n < 32) begin
			next_cycle();
			n++;
		end
		if (arst_n !== 1'b1) begin
			timeouts++;
			$display("reset was never released");
		end

		early = 1'b0;
		for (int frame = 0; frame < NUM_FRAMES && timeouts == 0; frame++) begin
			wait_sample(ok);
			if (!ok) break;
			model_frame(); // exactly one frame per offered sample
			exp_l = mix_channel(1'b0);
			exp_r = mix_channel(1'b1);
			check_value("o_smp_left", {16'h0000, exp_l}, {16'h0000, smp_left});
			check_value("o_smp_right", {16'h0000, exp_r}, {16'h0000, smp_right});
			samples++;
			if (early) begin
				next_cycle(); // ready already high, taken on this edge
				smp_ready = 1'b0;
			end else begin
				if (frame == 0) fill_wave(); // ram is undefined until written
				for (int v = 0; v < NV; v++) begin
					read_check({5'b11111, v[2:0]});
				end
				random_bus_ops(frame == 0 ? 48 : 6);
				reconfigure_voices();
				r = next_rand();
				hold_stretch(int'(r[3:0]), exp_l, exp_r);
				accept_sample();
			end
			r = next_rand();
			early     = (r[1:0] == 2'b00); // ready waiting before valid
			smp_ready = early;
		end

		$display("summary: %0d samples checked, %0d value errors, %0d timeouts",
		         samples, errors, timeouts);
		if (errors == 0 && timeouts == 0 && samples == NUM_FRAMES) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: wsg_top.f
common/wsg_pkg.sv
voice_regs/voice_regs.sv
verilog/phase_engine.sv
mixer/stereo_mixer.sv
verilog/wsg_top.sv
tests/tb_clk_gen.sv
tests/wsg_props.sv
tests/wsg_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = wsg_tb
FILELIST  = wsg_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
